/* include/icache_macros.svh */
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// cache geometry
`define ICACHE_WAYS 2
`define ICACHE_SETS 128

// set index field, 128 sets of 32-byte blocks
`define ICACHE_INDEX_LO 5
`define ICACHE_INDEX_HI 11

// tag starts right above the index
`define ICACHE_TAG_LO 12

// word pair select inside a block
`define ICACHE_PAIR_LO 3

// one refill burst covers a whole block
`define ICACHE_BURST_LEN 8

`endif

/* logic/icache_addr_pkg.sv */
`include "icache_macros.svh"

package icache_addr_pkg;

    // byte address, physical equals virtual
    typedef logic [31:0] addr_t;

    // address fields
    typedef logic [31-`ICACHE_TAG_LO:0] tag_t;
    typedef logic [`ICACHE_INDEX_HI-`ICACHE_INDEX_LO:0] set_idx_t;
    typedef logic [`ICACHE_INDEX_LO-`ICACHE_PAIR_LO-1:0] pair_idx_t;

    // instruction data
    typedef logic [31:0] inst_t;
    // low word sits at the lower address
    typedef logic [63:0] inst_pair_t;

    // one bit per way
    typedef logic [`ICACHE_WAYS-1:0] way_mask_t;

    // one bit per instruction slot of the pair
    typedef logic [1:0] slot_mask_t;

endpackage

/* logic/icache_ctrl_pkg.sv */
package icache_ctrl_pkg;

    // refill sequencing
    typedef enum logic [1:0] {
        RF_IDLE,
        RF_REQ,
        RF_BEATS
    } refill_state_e;

    // one tag store entry
    typedef struct packed {
        logic                  valid;
        icache_addr_pkg::tag_t tag;
    } tag_entry_t;

endpackage

/* logic/refill_if.sv */
interface refill_if;

    // target location
    icache_addr_pkg::set_idx_t   set_idx;
    icache_addr_pkg::pair_idx_t  pair_idx;
    icache_addr_pkg::way_mask_t  way_sel;

    // data array write
    logic                        pair_we;
    icache_addr_pkg::inst_pair_t pair_data;

    // tag array write, valid bit travels with the tag
    logic                        tag_we;
    icache_ctrl_pkg::tag_entry_t tag;

    modport ctrl (
        output set_idx, pair_idx, way_sel, pair_we, pair_data, tag_we, tag
    );

    modport tag_sink (
        input set_idx, way_sel, tag_we, tag
    );

    modport data_sink (
        input set_idx, pair_idx, way_sel, pair_we, pair_data
    );

endinterface

/* logic/refill_beat_counter.sv */
`include "icache_macros.svh"

module refill_beat_counter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start_i,
    input  logic                        beat_i,
    input  icache_addr_pkg::inst_t      beat_data_i,
    output logic                        pair_done_o,
    output icache_addr_pkg::pair_idx_t  pair_idx_o,
    output icache_addr_pkg::inst_pair_t pair_data_o,
    output logic                        last_o
);

    // one extra bit so the count can reach the burst length
    localparam int CNT_W = $clog2(`ICACHE_BURST_LEN) + 1;

    logic [CNT_W-1:0]       cnt_q;
    icache_addr_pkg::inst_t even_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (start_i) begin
            cnt_q <= '0;
        end else if (beat_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // lower word of the pair waits here
    always_ff @(posedge clk) begin
        if (beat_i && !cnt_q[0]) begin
            even_q <= beat_data_i;
        end
    end

    assign pair_done_o = beat_i & cnt_q[0];
    assign pair_idx_o  = cnt_q[CNT_W-2:1];
    assign pair_data_o = {beat_data_i, even_q};
    assign last_o      = beat_i && (cnt_q == CNT_W'(`ICACHE_BURST_LEN - 1));

    a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
        cnt_q <= CNT_W'(`ICACHE_BURST_LEN));

endmodule

/* logic/icache_refill_fsm.sv */
`include "icache_macros.svh"

module icache_refill_fsm (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        miss_i,
    input  icache_addr_pkg::addr_t      miss_addr_i,
    input  icache_addr_pkg::way_mask_t  victim_way_i,
    input  logic                        axi_resp_ready_i,
    input  logic                        axi_data_valid_i,
    input  icache_addr_pkg::inst_t      axi_data_i,
    output logic                        stall_o,
    output logic                        addr_valid_o,
    output icache_addr_pkg::addr_t      addr_o,
    output logic [3:0]                  data_len_o,
    output logic                        fill_valid_o,
    output icache_addr_pkg::inst_pair_t fill_pair_o,
    refill_if.ctrl                      refill
);

    icache_ctrl_pkg::refill_state_e state_q, state_d;

    icache_addr_pkg::addr_t      miss_addr_q;
    icache_addr_pkg::addr_t      req_addr;
    icache_addr_pkg::way_mask_t  victim_q;
    icache_addr_pkg::inst_pair_t fill_pair_q;
    logic                        fill_valid_q;
    logic                        miss_go;
    logic                        beat;
    logic                        pair_done;
    logic                        last_beat;
    icache_addr_pkg::pair_idx_t  pair_idx;
    icache_addr_pkg::inst_pair_t pair_data;

    // stale compare in the delivery cycle must not start another refill
    assign miss_go = (state_q == icache_ctrl_pkg::RF_IDLE) && miss_i && !fill_valid_q;
    assign beat    = axi_data_valid_i && (state_q == icache_ctrl_pkg::RF_BEATS);

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_ctrl_pkg::RF_IDLE: begin
                if (miss_go) begin
                    state_d = axi_resp_ready_i ? icache_ctrl_pkg::RF_BEATS
                                               : icache_ctrl_pkg::RF_REQ;
                end
            end
            icache_ctrl_pkg::RF_REQ: begin
                if (axi_resp_ready_i) begin
                    state_d = icache_ctrl_pkg::RF_BEATS;
                end
            end
            icache_ctrl_pkg::RF_BEATS: begin
                if (last_beat) begin
                    state_d = icache_ctrl_pkg::RF_IDLE;
                end
            end
            default: state_d = icache_ctrl_pkg::RF_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q      <= icache_ctrl_pkg::RF_IDLE;
            fill_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            fill_valid_q <= beat && last_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (miss_go) begin
            miss_addr_q <= miss_addr_i;
            victim_q    <= victim_way_i;
        end
        // keep the pair the stalled fetch is waiting for
        if (pair_done && pair_idx == miss_addr_q[`ICACHE_INDEX_LO-1:`ICACHE_PAIR_LO]) begin
            fill_pair_q <= pair_data;
        end
    end

    refill_beat_counter u_beat_cnt (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (addr_valid_o && axi_resp_ready_i),
        .beat_i      (beat),
        .beat_data_i (axi_data_i),
        .pair_done_o (pair_done),
        .pair_idx_o  (pair_idx),
        .pair_data_o (pair_data),
        .last_o      (last_beat)
    );

    // bus request, block aligned
    assign req_addr     = (state_q == icache_ctrl_pkg::RF_IDLE) ? miss_addr_i : miss_addr_q;
    assign addr_o       = {req_addr[31:`ICACHE_INDEX_LO], {`ICACHE_INDEX_LO{1'b0}}};
    assign addr_valid_o = miss_go || (state_q == icache_ctrl_pkg::RF_REQ);
    assign data_len_o   = 4'(`ICACHE_BURST_LEN);

    assign stall_o      = (state_q != icache_ctrl_pkg::RF_IDLE) || fill_valid_q || miss_i;
    assign fill_valid_o = fill_valid_q;
    assign fill_pair_o  = fill_pair_q;

    // array writes
    assign refill.set_idx   = miss_addr_q[`ICACHE_INDEX_HI:`ICACHE_INDEX_LO];
    assign refill.pair_idx  = pair_idx;
    assign refill.way_sel   = victim_q;
    assign refill.pair_we   = pair_done;
    assign refill.pair_data = pair_data;
    assign refill.tag_we    = last_beat;
    assign refill.tag.valid = 1'b1;
    assign refill.tag.tag   = miss_addr_q[31:`ICACHE_TAG_LO];

    a_req_state: assert property (@(posedge clk) disable iff (!rst_n)
        addr_valid_o |-> (state_q == icache_ctrl_pkg::RF_REQ)
                      || (state_q == icache_ctrl_pkg::RF_IDLE && miss_i));

endmodule

/* logic/icache_tag_array.sv */
`include "icache_macros.svh"

module icache_tag_array (
    input  logic                       clk,
    input  logic                       rst_n,
    input  icache_addr_pkg::set_idx_t  rd_set_i,
    input  icache_addr_pkg::tag_t      cmp_tag_i,
    refill_if.tag_sink                 refill,
    output icache_addr_pkg::way_mask_t hit_way_o,
    output icache_addr_pkg::way_mask_t victim_way_o
);

    icache_ctrl_pkg::tag_entry_t tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
    icache_ctrl_pkg::tag_entry_t rd_entry_q [`ICACHE_WAYS];
    logic [`ICACHE_SETS-1:0]     repl_bits;
    logic                        repl_q;

    // reset invalidates every entry
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                for (int s = 0; s < `ICACHE_SETS; s++) begin
                    tag_mem[w][s] <= '0;
                end
            end
        end else if (refill.tag_we) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (refill.way_sel[w]) begin
                    tag_mem[w][refill.set_idx] <= refill.tag;
                end
            end
        end
    end

    // victim flips once the set has been refilled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            repl_bits <= '0;
        end else if (refill.tag_we) begin
            repl_bits[refill.set_idx] <= ~repl_bits[refill.set_idx];
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            rd_entry_q[w] <= tag_mem[w][rd_set_i];
        end
        repl_q <= repl_bits[rd_set_i];
    end

    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit_way_o[w] = rd_entry_q[w].valid && (rd_entry_q[w].tag == cmp_tag_i);
        end
    end

    assign victim_way_o = icache_addr_pkg::way_mask_t'(1) << repl_q;

    a_tag_we_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        refill.tag_we |-> $onehot(refill.way_sel));

endmodule

/* logic/icache_data_array.sv */
`include "icache_macros.svh"

module icache_data_array (
    input  logic                        clk,
    input  icache_addr_pkg::set_idx_t   rd_set_i,
    input  icache_addr_pkg::pair_idx_t  rd_pair_i,
    input  icache_addr_pkg::way_mask_t  hit_way_i,
    refill_if.data_sink                 refill,
    output icache_addr_pkg::inst_pair_t rd_pair_o
);

    localparam int PAIRS_PER_SET = `ICACHE_BURST_LEN / 2;
    localparam int DEPTH         = `ICACHE_SETS * PAIRS_PER_SET;
    localparam int AW            = $bits(icache_addr_pkg::set_idx_t)
                                 + $bits(icache_addr_pkg::pair_idx_t);

    logic [AW-1:0]               rd_addr;
    logic [AW-1:0]               wr_addr;
    icache_addr_pkg::inst_pair_t pair_mem [`ICACHE_WAYS][DEPTH];
    icache_addr_pkg::inst_pair_t rd_q [`ICACHE_WAYS];

    // set index above pair index
    assign rd_addr = {rd_set_i, rd_pair_i};
    assign wr_addr = {refill.set_idx, refill.pair_idx};

    always_ff @(posedge clk) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (refill.pair_we && refill.way_sel[w]) begin
                pair_mem[w][wr_addr] <= refill.pair_data;
            end
        end
    end

    // all ways read in parallel, way picked after compare
    always_ff @(posedge clk) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            rd_q[w] <= pair_mem[w][rd_addr];
        end
    end

    always_comb begin
        rd_pair_o = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (hit_way_i[w]) begin
                rd_pair_o = rd_pair_o | rd_q[w];
            end
        end
    end

endmodule

/* logic/icache_top.sv */
`include "icache_macros.svh"

module icache_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush_i,
    input  logic                        fetch_valid_i,
    input  icache_addr_pkg::addr_t      fetch_pc_i,
    input  icache_addr_pkg::slot_mask_t fetch_mask_i,
    input  logic                        axi_resp_ready_i,
    input  logic                        axi_data_valid_i,
    input  icache_addr_pkg::inst_t      axi_data_i,
    output logic                        fetch_ready_o,
    output logic                        insts_valid_o,
    output icache_addr_pkg::inst_pair_t insts_o,
    output icache_addr_pkg::addr_t      insts_pc_o,
    output logic                        addr_valid_o,
    output icache_addr_pkg::addr_t      addr_o,
    output logic [3:0]                  data_len_o
);

    logic                        s2_valid_q;
    icache_addr_pkg::addr_t      s2_pc_q;
    icache_addr_pkg::slot_mask_t s2_mask_q;
    icache_addr_pkg::way_mask_t  hit_way;
    icache_addr_pkg::way_mask_t  victim_way;
    icache_addr_pkg::inst_pair_t rd_pair;
    icache_addr_pkg::inst_pair_t fill_pair;
    logic                        fill_valid;
    logic                        stall;
    logic                        lookup;
    logic                        miss;

    refill_if u_refill ();

    // compare stage, pc kept pair aligned
    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            s2_valid_q <= 1'b0;
            s2_pc_q    <= '0;
            s2_mask_q  <= '0;
        end else if (fetch_ready_o) begin
            s2_valid_q <= fetch_valid_i;
            s2_pc_q    <= {fetch_pc_i[31:`ICACHE_PAIR_LO], {`ICACHE_PAIR_LO{1'b0}}};
            s2_mask_q  <= fetch_mask_i;
        end else if (fill_valid) begin
            s2_valid_q <= 1'b0;
        end
    end

    assign lookup = s2_valid_q && (|s2_mask_q) && !flush_i;
    assign miss   = lookup && !(|hit_way);

    icache_tag_array u_tag_array (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_set_i     (fetch_pc_i[`ICACHE_INDEX_HI:`ICACHE_INDEX_LO]),
        .cmp_tag_i    (s2_pc_q[31:`ICACHE_TAG_LO]),
        .refill       (u_refill),
        .hit_way_o    (hit_way),
        .victim_way_o (victim_way)
    );

    icache_data_array u_data_array (
        .clk       (clk),
        .rd_set_i  (fetch_pc_i[`ICACHE_INDEX_HI:`ICACHE_INDEX_LO]),
        .rd_pair_i (fetch_pc_i[`ICACHE_INDEX_LO-1:`ICACHE_PAIR_LO]),
        .hit_way_i (hit_way),
        .refill    (u_refill),
        .rd_pair_o (rd_pair)
    );

    icache_refill_fsm u_refill_fsm (
        .clk              (clk),
        .rst_n            (rst_n),
        .miss_i           (miss),
        .miss_addr_i      (s2_pc_q),
        .victim_way_i     (victim_way),
        .axi_resp_ready_i (axi_resp_ready_i),
        .axi_data_valid_i (axi_data_valid_i),
        .axi_data_i       (axi_data_i),
        .stall_o          (stall),
        .addr_valid_o     (addr_valid_o),
        .addr_o           (addr_o),
        .data_len_o       (data_len_o),
        .fill_valid_o     (fill_valid),
        .fill_pair_o      (fill_pair),
        .refill           (u_refill)
    );

    assign fetch_ready_o = !stall;

    // hit path only while no refill is in flight
    assign insts_valid_o = lookup && (((|hit_way) && !stall) || fill_valid);
    assign insts_o       = fill_valid ? fill_pair : rd_pair;
    assign insts_pc_o    = s2_pc_q;

endmodule

/* verif/icache_mem_model.sv */
module icache_mem_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        addr_valid_i,
    input  logic [31:0] addr_i,
    input  logic [3:0]  data_len_i,
    output logic        resp_ready_o,
    output logic        data_valid_o,
    output logic [31:0] data_o
);

    localparam int          DRIVE_DLY = 10;
    localparam logic [31:0] PATTERN   = 32'ha5a5_0000;

    logic [31:0] lcg_state;
    logic [31:0] base;
    int          len;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // 0 to 3 idle cycles
    task automatic random_gap();
        int gap;
        lcg_state = lcg_next(lcg_state);
        gap = int'(lcg_state[17:16]);
        repeat (gap) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    initial begin
        lcg_state    = 32'h6f04;
        resp_ready_o = 1'b0;
        data_valid_o = 1'b0;
        data_o       = '0;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            if (rst_n && addr_valid_i) begin
                base = addr_i;
                len  = int'(data_len_i);
                random_gap();
                resp_ready_o = 1'b1;
                @(posedge clk);
                #DRIVE_DLY;
                resp_ready_o = 1'b0;
                // one word per beat, ascending addresses
                for (int i = 0; i < len; i++) begin
                    random_gap();
                    data_valid_o = 1'b1;
                    data_o       = (base + 32'(4 * i)) ^ PATTERN;
                    @(posedge clk);
                    #DRIVE_DLY;
                    data_valid_o = 1'b0;
                end
            end
        end
    end

endmodule

/* verif/icache_tb.sv */
`include "icache_macros.svh"

module icache_tb;

    localparam int          HALF_PERIOD = 50;
    localparam int          DRIVE_DLY   = 10;
    localparam int          WAIT_LIMIT  = 100;
    localparam logic [31:0] PATTERN     = 32'ha5a5_0000;

    // A, B and C all map to set 0x15
    localparam logic [31:0] PC_A = 32'h0001_02a8;
    localparam logic [31:0] PC_B = 32'h0002_02b0;
    localparam logic [31:0] PC_C = 32'h0003_02b8;
    localparam logic [31:0] PC_D = 32'h0000_0040;
    localparam logic [31:0] PC_E = 32'h0004_0100;

    logic        clk;
    logic        rst_n;
    logic        flush;
    logic        fetch_valid;
    logic [31:0] fetch_pc;
    logic [1:0]  fetch_mask;
    logic        mem_resp_ready;
    logic        mem_data_valid;
    logic [31:0] mem_data;
    logic        fetch_ready;
    logic        insts_valid;
    logic [63:0] insts;
    logic [31:0] insts_pc;
    logic        addr_valid;
    logic [31:0] addr;
    logic [3:0]  data_len;
    logic        fetch_accept;
    logic        expect_hit;
    logic        expect_miss;
    logic [31:0] req_pc;
    int          check_errs;
    int          timeout_errs;
    int          deliveries;
    int          expected_deliveries;

    always #(HALF_PERIOD) clk = ~clk;

    icache_top UUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush_i          (flush),
        .fetch_valid_i    (fetch_valid),
        .fetch_pc_i       (fetch_pc),
        .fetch_mask_i     (fetch_mask),
        .axi_resp_ready_i (mem_resp_ready),
        .axi_data_valid_i (mem_data_valid),
        .axi_data_i       (mem_data),
        .fetch_ready_o    (fetch_ready),
        .insts_valid_o    (insts_valid),
        .insts_o          (insts),
        .insts_pc_o       (insts_pc),
        .addr_valid_o     (addr_valid),
        .addr_o           (addr),
        .data_len_o       (data_len)
    );

    icache_mem_model u_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .addr_valid_i (addr_valid),
        .addr_i       (addr),
        .data_len_i   (data_len),
        .resp_ready_o (mem_resp_ready),
        .data_valid_o (mem_data_valid),
        .data_o       (mem_data)
    );

    assign fetch_accept = fetch_valid && fetch_ready;

    // low word belongs to the lower address
    function automatic logic [63:0] expected_pair(input logic [31:0] pc);
        return {(pc + 32'd4) ^ PATTERN, pc ^ PATTERN};
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        check_errs++;
        $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    // holds the request until an edge with fetch_ready high
    task automatic issue_fetch(input logic [31:0] pc, input logic [1:0] mask,
                               input logic hit, input logic miss);
        logic taken;
        int   n;
        taken       = 1'b0;
        n           = 0;
        fetch_valid = 1'b1;
        fetch_pc    = pc;
        fetch_mask  = mask;
        req_pc      = pc;
        expect_hit  = hit;
        expect_miss = miss;
        while (!taken && n < WAIT_LIMIT) begin
            @(negedge clk);
            taken = fetch_ready;
            @(posedge clk);
            #DRIVE_DLY;
            n++;
        end
        fetch_valid = 1'b0;
        expect_hit  = 1'b0;
        expect_miss = 1'b0;
        if (!taken) begin
            timeout_errs++;
            $display("%0t: fetch of %h not accepted within %0d cycles", $time, pc, WAIT_LIMIT);
        end
    endtask

    task automatic wait_delivery();
        logic seen;
        int   n;
        seen = 1'b0;
        n    = 0;
        expected_deliveries++;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clk);
            seen = insts_valid;
            n++;
        end
        @(posedge clk);
        #DRIVE_DLY;
        if (!seen) begin
            timeout_errs++;
            $display("%0t: no instruction pair delivered within %0d cycles", $time, WAIT_LIMIT);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && insts_valid) begin
            deliveries++;
        end
    end

    a_rst_addr: assert property (@(posedge clk) $rose(rst_n) |-> !addr_valid)
        else report_mismatch("addr_valid_o", 64'd0, 64'($sampled(addr_valid)));
    a_rst_insts: assert property (@(posedge clk) $rose(rst_n) |-> !insts_valid)
        else report_mismatch("insts_valid_o", 64'd0, 64'($sampled(insts_valid)));
    a_rst_ready: assert property (@(posedge clk) $rose(rst_n) |-> fetch_ready)
        else report_mismatch("fetch_ready_o", 64'd1, 64'($sampled(fetch_ready)));

    a_req_align: assert property (@(posedge clk) disable iff (!rst_n)
        addr_valid |-> addr == {req_pc[31:`ICACHE_INDEX_LO], {`ICACHE_INDEX_LO{1'b0}}})
        else report_mismatch("addr_o", 64'({$sampled(req_pc[31:5]), 5'b0}), 64'($sampled(addr)));
    a_req_len: assert property (@(posedge clk) disable iff (!rst_n)
        addr_valid |-> data_len == 4'd8)
        else report_mismatch("data_len_o", 64'd8, 64'($sampled(data_len)));
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        addr_valid && !mem_resp_ready |=> addr_valid)
        else report_mismatch("addr_valid_o", 64'd1, 64'($sampled(addr_valid)));
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        addr_valid && !mem_resp_ready |=> $stable(addr))
        else report_mismatch("addr_o", 64'({$sampled(req_pc[31:5]), 5'b0}), 64'($sampled(addr)));
    a_req_stall: assert property (@(posedge clk) disable iff (!rst_n)
        addr_valid |-> !fetch_ready)
        else report_mismatch("fetch_ready_o", 64'd0, 64'($sampled(fetch_ready)));
    // ready comes back only right after the delivery pulse
    a_ready_return: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(fetch_ready) |-> $past(insts_valid))
        else report_mismatch("insts_valid_o", 64'd1, 64'd0);

    a_pair_pc: assert property (@(posedge clk) disable iff (!rst_n)
        insts_valid |-> insts_pc == {req_pc[31:`ICACHE_PAIR_LO], {`ICACHE_PAIR_LO{1'b0}}})
        else report_mismatch("insts_pc_o", 64'({$sampled(req_pc[31:3]), 3'b0}),
                             64'($sampled(insts_pc)));
    a_pair_data: assert property (@(posedge clk) disable iff (!rst_n)
        insts_valid |-> insts == expected_pair(insts_pc))
        else report_mismatch("insts_o", expected_pair($sampled(insts_pc)), $sampled(insts));

    a_hit_valid: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_accept && expect_hit |=> insts_valid)
        else report_mismatch("insts_valid_o", 64'd1, 64'($sampled(insts_valid)));
    a_hit_no_req: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_accept && expect_hit |=> !addr_valid)
        else report_mismatch("addr_valid_o", 64'd0, 64'($sampled(addr_valid)));
    a_miss_req: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_accept && expect_miss |=> addr_valid)
        else report_mismatch("addr_valid_o", 64'd1, 64'($sampled(addr_valid)));
    a_miss_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_accept && expect_miss |=> !insts_valid)
        else report_mismatch("insts_valid_o", 64'd0, 64'($sampled(insts_valid)));

    a_flush_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        flush |-> !insts_valid)
        else report_mismatch("insts_valid_o", 64'd0, 64'($sampled(insts_valid)));
    a_empty_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_accept && fetch_mask == 2'b00 |=> !insts_valid)
        else report_mismatch("insts_valid_o", 64'd0, 64'($sampled(insts_valid)));
    a_empty_no_req: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_accept && fetch_mask == 2'b00 |=> !addr_valid)
        else report_mismatch("addr_valid_o", 64'd0, 64'($sampled(addr_valid)));

    initial begin
        clk                 = 1'b0;
        rst_n               = 1'b0;
        flush               = 1'b0;
        fetch_valid         = 1'b0;
        fetch_pc            = '0;
        fetch_mask          = '0;
        req_pc              = '0;
        expect_hit          = 1'b0;
        expect_miss         = 1'b0;
        check_errs          = 0;
        timeout_errs        = 0;
        deliveries          = 0;
        expected_deliveries = 0;
        idle_cycles(3);
        rst_n = 1'b1;
        idle_cycles(1);

        // cold miss, then hits inside the same block
        issue_fetch(PC_D, 2'b11, 1'b0, 1'b1);
        wait_delivery();
        issue_fetch(PC_D + 32'd8, 2'b11, 1'b1, 1'b0);
        wait_delivery();
        issue_fetch(PC_D, 2'b11, 1'b1, 1'b0);
        wait_delivery();

        // A and B fill both ways of set 0x15
        issue_fetch(PC_A, 2'b11, 1'b0, 1'b1);
        wait_delivery();
        issue_fetch(PC_B, 2'b11, 1'b0, 1'b1);
        wait_delivery();
        issue_fetch(PC_A, 2'b11, 1'b1, 1'b0);
        wait_delivery();
        issue_fetch(PC_B, 2'b11, 1'b1, 1'b0);
        wait_delivery();

        // C takes way 0 from A
        issue_fetch(PC_C, 2'b11, 1'b0, 1'b1);
        wait_delivery();
        issue_fetch(PC_B, 2'b11, 1'b1, 1'b0);
        wait_delivery();
        issue_fetch(PC_A, 2'b11, 1'b0, 1'b1);
        wait_delivery();

        // empty mask on a cold block
        issue_fetch(PC_E, 2'b00, 1'b0, 1'b0);
        idle_cycles(3);

        // flush one cycle after a hit is accepted
        issue_fetch(PC_D, 2'b11, 1'b0, 1'b0);
        flush = 1'b1;
        idle_cycles(1);
        flush = 1'b0;
        idle_cycles(3);

        issue_fetch(PC_D, 2'b11, 1'b1, 1'b0);
        wait_delivery();
        idle_cycles(3);

        if (deliveries != expected_deliveries) begin
            report_mismatch("delivery count", 64'(expected_deliveries), 64'(deliveries));
        end
        $display("check errors: %0d, timeouts: %0d", check_errs, timeout_errs);
        if (check_errs == 0 && timeout_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* icache_top.f */
+incdir+include
logic/icache_addr_pkg.sv
logic/icache_ctrl_pkg.sv
logic/refill_if.sv
logic/refill_beat_counter.sv
logic/icache_refill_fsm.sv
logic/icache_tag_array.sv
logic/icache_data_array.sv
logic/icache_top.sv
verif/icache_mem_model.sv
verif/icache_tb.sv

/* Makefile */
TOP := icache_tb

all: run

build:
	verilator --binary --timing --assert -f icache_top.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

lint:
	verilator --lint-only --timing --assert -f icache_top.f --top-module icache_top

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
